// ==== hdl/snd_pkg.sv ====
// Shared widths, sound CPU address map and bus read defaults
`default_nettype none

package snd_pkg;

    // Bus widths
    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int ram_aw = 12;

    // Memory map, top nibble 0xF is work RAM and the rest is program ROM
    localparam logic [3:0] ram_page = 4'hF;

    // I/O map
    localparam int io_hi_bit  = 7;
    localparam int pcm_rd_bit = 2;

    // Board register write offsets in the low address bits
    localparam logic [2:0] reg_pcm_lo  = 3'd0;
    localparam logic [2:0] reg_pcm_hi  = 3'd1;
    localparam logic [2:0] reg_pcm_cnt = 3'd2;
    localparam logic [2:0] reg_irq_clr = 3'd3;

    // Read defaults
    localparam logic [data_w-1:0] bus_idle = 8'hFF;
    localparam logic [data_w-1:0] vec_base = 8'hCF;

endpackage

`default_nettype wire

// ==== hdl/snd_decode.sv ====
// Sound CPU chip selects and the registered read-data mux
`default_nettype none

module snd_decode (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [snd_pkg::addr_w-1:0] addr,
    input  wire logic                       mreq_n,
    input  wire logic                       iorq_n,
    input  wire logic                       rd_n,
    input  wire logic                       wr_n,
    input  wire logic                       rfsh_n,
    input  wire logic                       m1_n,
    input  wire logic [snd_pkg::data_w-1:0] rom_data,
    input  wire logic [snd_pkg::data_w-1:0] ram_dout,
    input  wire logic [snd_pkg::data_w-1:0] latch,
    input  wire logic [snd_pkg::data_w-1:0] int_vec,
    input  wire logic [snd_pkg::data_w-1:0] pcm_byte,
    input  wire logic [snd_pkg::data_w-1:0] fm_dout,
    output logic                            rom_cs,
    output logic                            ram_cs,
    output logic                            ram_we,
    output logic                            fm_cs,
    output logic                            lo_cs,
    output logic                            hi_cs,
    output logic                            cnt_cs,
    output logic                            irq_clr,
    output logic                            pcm_rd,
    output logic [snd_pkg::data_w-1:0]      cpu_din
);
    import snd_pkg::*;

    logic mem_req;
    logic io_req;
    logic io_brd;
    logic io_rd;
    logic io_wr;
    logic latch_cs;
    logic int_cs;

    // Refresh cycles put the refresh address on the bus, ignore them
    assign mem_req = !mreq_n && rfsh_n;
    // Interrupt acknowledge also asserts iorq_n, keep it out of the I/O map
    assign io_req  = !iorq_n && m1_n;
    assign io_brd  = io_req && addr[io_hi_bit];
    assign io_rd   = io_brd && !rd_n;
    assign io_wr   = io_brd && !wr_n;

    assign rom_cs  = mem_req && addr[addr_w-1 -: 4] != ram_page;
    assign ram_cs  = mem_req && addr[addr_w-1 -: 4] == ram_page;
    assign ram_we  = ram_cs && !wr_n;
    assign fm_cs   = io_req && !addr[io_hi_bit];
    assign int_cs  = !m1_n && !iorq_n;

    // Board register reads
    assign latch_cs = io_rd && !addr[pcm_rd_bit];
    assign pcm_rd   = io_rd &&  addr[pcm_rd_bit];

    // Board register writes
    assign lo_cs   = io_wr && addr[2:0] == reg_pcm_lo;
    assign hi_cs   = io_wr && addr[2:0] == reg_pcm_hi;
    assign cnt_cs  = io_wr && addr[2:0] == reg_pcm_cnt;
    assign irq_clr = io_wr && addr[2:0] == reg_irq_clr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= bus_idle;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (ram_cs) begin
            cpu_din <= ram_dout;
        end else if (pcm_rd) begin
            cpu_din <= pcm_byte;
        end else if (latch_cs) begin
            cpu_din <= latch;
        end else if (int_cs) begin
            cpu_din <= int_vec;
        end else if (fm_cs) begin
            cpu_din <= fm_dout;
        end else begin
            cpu_din <= bus_idle;
        end
    end

    // No bus cycle may write two targets at once
    a_one_write: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ram_we, fm_cs && !wr_n, lo_cs, hi_cs, cnt_cs, irq_clr}));

endmodule

`default_nettype wire

// ==== hdl/snd_latch.sv ====
// Main-to-sound command latch, pending interrupt flag and acknowledge vector
`default_nettype none

module snd_latch (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [snd_pkg::data_w-1:0] main_dout,
    input  wire logic                       latch_wr,
    input  wire logic                       irq_clr,
    input  wire logic                       fm_intn,
    output logic [snd_pkg::data_w-1:0]      latch,
    output logic [snd_pkg::data_w-1:0]      int_vec,
    output logic                            int_n
);
    import snd_pkg::*;

    logic pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch   <= '0;
            pending <= 1'b0;
        end else if (latch_wr) begin
            // A new command beats a clear in the same cycle
            latch   <= main_dout;
            pending <= 1'b1;
        end else if (irq_clr) begin
            pending <= 1'b0;
        end
    end

    assign int_n = !pending && fm_intn;

    // Bits 5 and 4 tell the handler which source is active (low)
    assign int_vec = vec_base | {2'b00, !pending, fm_intn, 4'h0};

    // Command from main CPU must reach the sound CPU interrupt pin
    a_latch_int: assert property (@(posedge clk) disable iff (rst)
        latch_wr |=> !int_n);

endmodule

`default_nettype wire

// ==== hdl/pcm_player.sv ====
// PCM sample address register, count-up, sample ROM fetch and signed output
`default_nettype none

module pcm_player (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [snd_pkg::data_w-1:0] din,
    input  wire logic                       lo_cs,
    input  wire logic                       hi_cs,
    input  wire logic                       cnt_cs,
    input  wire logic [snd_pkg::data_w-1:0] pcm_data,
    input  wire logic                       pcm_ok,
    output logic                            pcm_cs,
    output logic [snd_pkg::addr_w-1:0]      pcm_addr,
    output logic [snd_pkg::data_w-1:0]      pcm_byte,
    output logic signed [snd_pkg::data_w-1:0] snd
);
    import snd_pkg::*;

    logic lo_l;
    logic hi_l;
    logic cnt_l;
    logic lo_rise;
    logic hi_rise;
    logic cnt_rise;
    logic start;

    // Strobes last the whole bus cycle, act once on the leading edge
    assign lo_rise  = lo_cs && !lo_l;
    assign hi_rise  = hi_cs && !hi_l;
    assign cnt_rise = cnt_cs && !cnt_l;
    assign start    = lo_rise || hi_rise || cnt_rise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lo_l     <= 1'b0;
            hi_l     <= 1'b0;
            cnt_l    <= 1'b0;
            pcm_addr <= '0;
            pcm_cs   <= 1'b0;
            pcm_byte <= '0;
            snd      <= '0;
        end else begin
            lo_l  <= lo_cs;
            hi_l  <= hi_cs;
            cnt_l <= cnt_cs;
            if (lo_rise) begin
                pcm_addr[data_w-1:0] <= din;
            end else if (hi_rise) begin
                pcm_addr[addr_w-1:data_w] <= din;
            end else if (cnt_rise) begin
                pcm_addr <= pcm_addr + 1'b1;
            end
            if (start) begin
                // Restart keeps cs high and drops any answer for the old address
                pcm_cs <= 1'b1;
            end else if (pcm_cs && pcm_ok) begin
                pcm_cs   <= 1'b0;
                pcm_byte <= pcm_data;
                // Offset binary to two's complement
                snd      <= signed'({!pcm_data[data_w-1], pcm_data[data_w-2:0]});
            end
        end
    end

    // The sample ROM sees one address for the life of a fetch
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        pcm_cs && !start |=> $stable(pcm_addr));

endmodule

`default_nettype wire

// ==== hdl/snd_ram.sv ====
// Sound CPU work RAM, 4 KB with synchronous read and write
`default_nettype none

module snd_ram (
    input  wire logic                       clk,
    input  wire logic [snd_pkg::ram_aw-1:0] addr,
    input  wire logic [snd_pkg::data_w-1:0] din,
    input  wire logic                       we,
    output logic [snd_pkg::data_w-1:0]      dout
);
    import snd_pkg::*;

    logic [data_w-1:0] mem [0:(1 << ram_aw)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        // Read-before-write on the same address
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/snd_top.sv ====
// Sound board glue top level: decoder, command latch, PCM player and work RAM
`default_nettype none

module snd_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // Sound CPU bus
    input  wire logic [snd_pkg::addr_w-1:0] addr,
    input  wire logic [snd_pkg::data_w-1:0] cpu_dout,
    input  wire logic                       mreq_n,
    input  wire logic                       iorq_n,
    input  wire logic                       rd_n,
    input  wire logic                       wr_n,
    input  wire logic                       rfsh_n,
    input  wire logic                       m1_n,
    output logic [snd_pkg::data_w-1:0]      cpu_din,
    output logic                            int_n,
    // From main CPU
    input  wire logic [snd_pkg::data_w-1:0] main_dout,
    input  wire logic                       latch_wr,
    // Program ROM
    input  wire logic [snd_pkg::data_w-1:0] rom_data,
    output logic                            rom_cs,
    // Sample ROM
    output logic                            pcm_cs,
    output logic [snd_pkg::addr_w-1:0]      pcm_addr,
    input  wire logic [snd_pkg::data_w-1:0] pcm_data,
    input  wire logic                       pcm_ok,
    // FM chip
    output logic                            fm_cs,
    input  wire logic [snd_pkg::data_w-1:0] fm_dout,
    input  wire logic                       fm_intn,
    output logic signed [snd_pkg::data_w-1:0] pcm
);
    import snd_pkg::*;

    logic [data_w-1:0] ram_dout;
    logic [data_w-1:0] latch;
    logic [data_w-1:0] int_vec;
    logic [data_w-1:0] pcm_byte;
    logic              ram_we;
    logic              lo_cs;
    logic              hi_cs;
    logic              cnt_cs;
    logic              irq_clr;

    // RAM and sample read selects only steer the decoder's own read mux
    snd_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .mreq_n   (mreq_n),
        .iorq_n   (iorq_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .rfsh_n   (rfsh_n),
        .m1_n     (m1_n),
        .rom_data (rom_data),
        .ram_dout (ram_dout),
        .latch    (latch),
        .int_vec  (int_vec),
        .pcm_byte (pcm_byte),
        .fm_dout  (fm_dout),
        .rom_cs   (rom_cs),
        .ram_cs   (),
        .ram_we   (ram_we),
        .fm_cs    (fm_cs),
        .lo_cs    (lo_cs),
        .hi_cs    (hi_cs),
        .cnt_cs   (cnt_cs),
        .irq_clr  (irq_clr),
        .pcm_rd   (),
        .cpu_din  (cpu_din)
    );

    snd_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .main_dout (main_dout),
        .latch_wr  (latch_wr),
        .irq_clr   (irq_clr),
        .fm_intn   (fm_intn),
        .latch     (latch),
        .int_vec   (int_vec),
        .int_n     (int_n)
    );

    pcm_player u_pcm (
        .clk      (clk),
        .rst      (rst),
        .din      (cpu_dout),
        .lo_cs    (lo_cs),
        .hi_cs    (hi_cs),
        .cnt_cs   (cnt_cs),
        .pcm_data (pcm_data),
        .pcm_ok   (pcm_ok),
        .pcm_cs   (pcm_cs),
        .pcm_addr (pcm_addr),
        .pcm_byte (pcm_byte),
        .snd      (pcm)
    );

    // Only the low address bits reach the RAM, the page is decoded above
    snd_ram u_ram (
        .clk  (clk),
        .addr (addr[ram_aw-1:0]),
        .din  (cpu_dout),
        .we   (ram_we),
        .dout (ram_dout)
    );

endmodule

`default_nettype wire

// ==== tb/snd_checker.sv ====
// Testbench checker: compares watched DUT outputs with expected values and keeps the counts
`default_nettype none

module snd_checker (
    input  wire logic        [7:0]  cpu_din,
    input  wire logic               int_n,
    input  wire logic               rom_cs,
    input  wire logic               fm_cs,
    input  wire logic               pcm_cs,
    input  wire logic        [15:0] pcm_addr,
    input  wire logic signed [7:0]  pcm,
    output int                      fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int passes = 0;
    int fails = 0;

    assign fail_count = fails;

    // Called on the last falling edge of a bus cycle, when every output is settled
    task automatic compare(input string name, input string sel, input logic [15:0] exp);
        logic [15:0] act;
        logic        known;
        known = 1'b1;
        act   = '0;
        if (sel == "din") act = {8'h00, cpu_din};
        else if (sel == "int_n") act = {15'd0, int_n};
        else if (sel == "rom_cs") act = {15'd0, rom_cs};
        else if (sel == "fm_cs") act = {15'd0, fm_cs};
        else if (sel == "cs") act = {15'd0, pcm_cs};
        else if (sel == "addr") act = pcm_addr;
        else if (sel == "pcm") act = {8'h00, pcm};
        else known = 1'b0;
        if (!known) begin
            fails++;
            $display("Test %s asks for signal %s, which the checker does not watch", name, sel);
        end else if (act !== exp) begin
            fails++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end else begin
            passes++;
            $display("%s ok", name);
        end
    endtask

    task automatic summary();
        $display("%0d tests run, %0d passed, %0d failed", passes + fails, passes, fails);
    endtask

endmodule

`default_nettype wire

// ==== tb/tb_snd.sv ====
// Testbench top: clock, reset, sound CPU bus cycles, sample ROM model and stimulus table
`default_nettype none

module tb_snd;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {OP_MWR, OP_MRD, OP_IOWR, OP_IORD, OP_INTA, OP_LATCH} op_t;

    // fmi drives fm_intn, pend keeps the sample ROM silent so the next cycle overlaps
    typedef struct {
        string       name;
        op_t         op;
        logic [15:0] addr;
        logic [7:0]  data;
        string       sel;
        logic [15:0] exp;
        logic        fmi;
        logic        pend;
    } test_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] addr;
    logic [7:0]  cpu_dout;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        rfsh_n;
    logic        m1_n;
    logic [7:0]  main_dout;
    logic        latch_wr;
    logic [7:0]  rom_data;
    logic [7:0]  fm_dout;
    logic        fm_intn;
    logic [7:0]  pcm_data = 8'h00;
    logic        pcm_ok = 1'b0;
    logic [7:0]  cpu_din;
    logic        int_n;
    logic        rom_cs;
    logic        pcm_cs;
    logic [15:0] pcm_addr;
    logic        fm_cs;
    logic signed [7:0] pcm;
    int          fail_count;
    logic        timed_out;
    logic        fetch_ok;

    // Sample ROM model state
    logic        rom_hold = 1'b0;
    logic [31:0] rng = 32'd17;
    logic [15:0] req_addr = 16'h0000;
    logic        busy = 1'b0;
    int          delay = 0;

    test_t tests[$];

    always #5 clk = ~clk;

    snd_top snd_top_i (
        .clk(clk), .rst(rst), .addr(addr), .cpu_dout(cpu_dout),
        .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
        .rfsh_n(rfsh_n), .m1_n(m1_n), .cpu_din(cpu_din), .int_n(int_n),
        .main_dout(main_dout), .latch_wr(latch_wr), .rom_data(rom_data), .rom_cs(rom_cs),
        .pcm_cs(pcm_cs), .pcm_addr(pcm_addr), .pcm_data(pcm_data), .pcm_ok(pcm_ok),
        .fm_cs(fm_cs), .fm_dout(fm_dout), .fm_intn(fm_intn), .pcm(pcm)
    );

    snd_checker u_checker (
        .cpu_din(cpu_din), .int_n(int_n), .rom_cs(rom_cs), .fm_cs(fm_cs),
        .pcm_cs(pcm_cs), .pcm_addr(pcm_addr), .pcm(pcm), .fail_count(fail_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Sample ROM answers hi ^ lo after 1 to 6 cycles, a new address restarts the wait
    always @(negedge clk) begin
        if (rst || !pcm_cs) begin
            pcm_ok = 1'b0;
            busy   = 1'b0;
        end else if (!busy || pcm_ok || pcm_addr != req_addr) begin
            pcm_ok   = 1'b0;
            busy     = 1'b1;
            req_addr = pcm_addr;
            rng      = xorshift(rng);
            delay    = 1 + int'(rng % 6);
        end else if (delay > 1) begin
            delay = delay - 1;
        end else if (!rom_hold) begin
            pcm_data = req_addr[15:8] ^ req_addr[7:0];
            pcm_ok   = 1'b1;
        end
    end

    task automatic add_test(input string name, input op_t op, input logic [15:0] a,
                            input logic [7:0] d, input string sel, input logic [15:0] exp,
                            input logic fmi, input logic pend);
        test_t t;
        t.name = name;
        t.op   = op;
        t.addr = a;
        t.data = d;
        t.sel  = sel;
        t.exp  = exp;
        t.fmi  = fmi;
        t.pend = pend;
        tests.push_back(t);
    endtask

    task automatic wait_fetch(input string name, output logic ok);
        int n;
        n = 0;
        while (pcm_cs && n < 50) begin
            @(negedge clk);
            n++;
        end
        ok = !pcm_cs;
        if (!ok) begin
            $display("Sample ROM fetch before test %s never completed, timed out", name);
        end
    endtask

    // One 4-clock bus cycle and an idle clock, outputs compared on the last held falling edge
    task automatic run_cycle(input test_t t);
        addr     = t.addr;
        cpu_dout = t.data;
        rom_data = t.data;
        fm_dout  = t.data;
        fm_intn  = t.fmi;
        rom_hold <= t.pend;
        case (t.op)
            OP_MWR: begin
                mreq_n = 1'b0;
                wr_n   = 1'b0;
            end
            OP_MRD: begin
                mreq_n = 1'b0;
                rd_n   = 1'b0;
            end
            OP_IOWR: begin
                iorq_n = 1'b0;
                wr_n   = 1'b0;
            end
            OP_IORD: begin
                iorq_n = 1'b0;
                rd_n   = 1'b0;
            end
            OP_INTA: begin
                m1_n   = 1'b0;
                iorq_n = 1'b0;
            end
            default: begin
                main_dout = t.data;
                latch_wr  = 1'b1;
            end
        endcase
        @(negedge clk);
        latch_wr = 1'b0;
        repeat (2) @(negedge clk);
        u_checker.compare(t.name, t.sel, t.exp);
        @(negedge clk);
        mreq_n  = 1'b1;
        iorq_n  = 1'b1;
        rd_n    = 1'b1;
        wr_n    = 1'b1;
        m1_n    = 1'b1;
        fm_intn = 1'b1;
        // Strobes go idle so back-to-back writes to one register each give a leading edge
        @(negedge clk);
    endtask

    initial begin
        addr      = '0;
        cpu_dout  = '0;
        mreq_n    = 1'b1;
        iorq_n    = 1'b1;
        rd_n      = 1'b1;
        wr_n      = 1'b1;
        rfsh_n    = 1'b1;
        m1_n      = 1'b1;
        main_dout = '0;
        latch_wr  = 1'b0;
        rom_data  = '0;
        fm_dout   = '0;
        fm_intn   = 1'b1;
        rst       = 1'b1;
        timed_out = 1'b0;
        fetch_ok  = 1'b1;

        add_test("reset_latch", OP_IORD, 16'h0080, 8'h00, "din", 16'h0000, 1'b1, 1'b0);
        add_test("reset_pcm", OP_IORD, 16'h0084, 8'h00, "pcm", 16'h0000, 1'b1, 1'b0);
        add_test("latch_set", OP_LATCH, 16'h0000, 8'h5A, "int_n", 16'h0000, 1'b1, 1'b0);
        add_test("latch_read", OP_IORD, 16'h0080, 8'h00, "din", 16'h005A, 1'b1, 1'b0);
        add_test("vec_pending", OP_INTA, 16'h0000, 8'h00, "din", 16'h00DF, 1'b1, 1'b0);
        add_test("irq_clear", OP_IOWR, 16'h0083, 8'h00, "int_n", 16'h0001, 1'b1, 1'b0);
        add_test("vec_clear", OP_INTA, 16'h0000, 8'h00, "din", 16'h00FF, 1'b1, 1'b0);
        add_test("vec_fm", OP_INTA, 16'h0000, 8'h00, "din", 16'h00EF, 1'b0, 1'b0);
        add_test("int_fm", OP_IOWR, 16'h0083, 8'h00, "int_n", 16'h0000, 1'b0, 1'b0);
        add_test("ram_wr_lo", OP_MWR, 16'hF000, 8'hA5, "rom_cs", 16'h0000, 1'b1, 1'b0);
        add_test("ram_wr_hi", OP_MWR, 16'hFFFF, 8'h3C, "rom_cs", 16'h0000, 1'b1, 1'b0);
        add_test("ram_rd_lo", OP_MRD, 16'hF000, 8'h00, "din", 16'h00A5, 1'b1, 1'b0);
        add_test("ram_rd_hi", OP_MRD, 16'hFFFF, 8'h00, "din", 16'h003C, 1'b1, 1'b0);
        add_test("rom_rd", OP_MRD, 16'h1234, 8'h96, "din", 16'h0096, 1'b1, 1'b0);
        add_test("rom_sel", OP_MRD, 16'h1234, 8'h96, "rom_cs", 16'h0001, 1'b1, 1'b0);
        add_test("pcm_lo", OP_IOWR, 16'h0080, 8'h34, "addr", 16'h0034, 1'b1, 1'b0);
        add_test("pcm_hi", OP_IOWR, 16'h0081, 8'h12, "addr", 16'h1234, 1'b1, 1'b0);
        add_test("pcm_sample", OP_IORD, 16'h0084, 8'h00, "pcm", 16'h00A6, 1'b1, 1'b0);
        add_test("pcm_raw", OP_IORD, 16'h0084, 8'h00, "din", 16'h0026, 1'b1, 1'b0);
        add_test("cnt_1", OP_IOWR, 16'h0082, 8'h00, "addr", 16'h1235, 1'b1, 1'b0);
        add_test("cnt_1_smp", OP_IORD, 16'h0084, 8'h00, "pcm", 16'h00A7, 1'b1, 1'b0);
        add_test("cnt_2", OP_IOWR, 16'h0082, 8'h00, "addr", 16'h1236, 1'b1, 1'b0);
        add_test("cnt_3", OP_IOWR, 16'h0082, 8'h00, "addr", 16'h1237, 1'b1, 1'b0);
        add_test("cnt_3_smp", OP_IORD, 16'h0084, 8'h00, "pcm", 16'h00A5, 1'b1, 1'b0);
        add_test("ovl_1", OP_IOWR, 16'h0082, 8'h00, "addr", 16'h1238, 1'b1, 1'b1);
        add_test("ovl_cs", OP_IORD, 16'h0080, 8'h00, "cs", 16'h0001, 1'b1, 1'b1);
        add_test("ovl_2", OP_IOWR, 16'h0082, 8'h00, "addr", 16'h1239, 1'b1, 1'b0);
        add_test("ovl_smp", OP_IORD, 16'h0084, 8'h00, "pcm", 16'h00AB, 1'b1, 1'b0);
        add_test("fm_wr", OP_IOWR, 16'h0001, 8'h00, "fm_cs", 16'h0001, 1'b1, 1'b0);
        add_test("fm_rd", OP_IORD, 16'h0000, 8'h6C, "din", 16'h006C, 1'b1, 1'b0);
        add_test("no_reg", OP_IOWR, 16'h0085, 8'h77, "addr", 16'h1239, 1'b1, 1'b0);
        add_test("recheck_latch", OP_IORD, 16'h0080, 8'h00, "din", 16'h005A, 1'b1, 1'b0);
        add_test("recheck_pcm", OP_IORD, 16'h0084, 8'h00, "din", 16'h002B, 1'b1, 1'b0);
        add_test("recheck_ram", OP_MRD, 16'hF000, 8'h00, "din", 16'h00A5, 1'b1, 1'b0);

        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < tests.size(); i++) begin
            // After an overlap entry the fetch is meant to be still running
            if (i == 0 || !tests[i-1].pend) begin
                wait_fetch(tests[i].name, fetch_ok);
            end
            if (!fetch_ok) begin
                timed_out = 1'b1;
                break;
            end
            run_cycle(tests[i]);
        end

        u_checker.summary();
        if (timed_out || fail_count != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/snd_pkg.sv
hdl/snd_decode.sv
hdl/snd_latch.sv
hdl/pcm_player.sv
hdl/snd_ram.sv
hdl/snd_top.sv
tb/snd_checker.sv
tb/tb_snd.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_snd -f sim.f -o tb_snd_sim
./obj_dir/tb_snd_sim > sim.log 2>&1
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
